//--- source/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

`define CACHE_ADDR_WIDTH            32
`define CACHE_BLOCK_WIDTH           64
`define CACHE_PORT_ID_WIDTH         2
`define CACHE_BYTE_MASK_WIDTH       (`CACHE_BLOCK_WIDTH / 8)
`define CACHE_PACKET_TYPE_WIDTH     2

`define CACHE_NUM_WAY               2

// store index comes from the address bits just above the block offset
`define CACHE_STORE_DEPTH           4
`define CACHE_QUEUE_DEPTH           4

// cycles a way may wait on an ack or a return
`define CACHE_TIMEOUT_CYCLES        64

`endif

//--- source/cache_packet_pkg.sv
package cache_packet_pkg;

    `include "cache_params.svh"

    typedef logic [`CACHE_ADDR_WIDTH-1:0]         cache_addr_t;
    typedef logic [`CACHE_BLOCK_WIDTH-1:0]        cache_block_t;
    typedef logic [`CACHE_PORT_ID_WIDTH-1:0]      cache_port_id_t;
    typedef logic [`CACHE_BYTE_MASK_WIDTH-1:0]    cache_byte_mask_t;
    typedef logic [`CACHE_PACKET_TYPE_WIDTH-1:0]  cache_packet_type_t;

    // request word, field order follows the cache port layout
    typedef struct packed
    {
        logic               cacheable;
        logic               write;
        logic               valid;
        cache_port_id_t     port;
        cache_byte_mask_t   byte_mask;
        cache_packet_type_t pkt_type;
        cache_block_t       data;
        cache_addr_t        addr;
    } cache_packet_t;

    typedef struct packed
    {
        logic               valid;
        cache_port_id_t     port;           // steers the return back to its way
        cache_block_t       data;
        cache_addr_t        addr;
    } cache_return_t;

endpackage

//--- source/cache_test_pkg.sv
package cache_test_pkg;

    import cache_packet_pkg::*;

    typedef enum logic [2:0]
    {
        way_idle,
        way_issue,
        way_wait_return,
        way_done,
        way_failed                          // sticky until the next start
    } way_state_t;

    typedef struct packed
    {
        logic               done;
        logic               error;
        cache_block_t       read_block;
    } test_result_t;

endpackage

//--- source/cache_port_if.sv
`timescale 1ns/1ps

interface cache_port_if
    import cache_packet_pkg::*;
();

    cache_packet_t  request_packet;         // held with valid set until acked
    logic           request_ack;            // one cycle per accepted request
    cache_return_t  return_packet;          // held with valid set until acked
    logic           return_ack;

    modport generator
    (
        output request_packet,
        output return_ack,
        input  request_ack,
        input  return_packet
    );

    modport cache
    (
        input  request_packet,
        input  return_ack,
        output request_ack,
        output return_packet
    );

endinterface

//--- source/packet_queue.sv
`timescale 1ns/1ps

module packet_queue
#(
    parameter type payload_t = logic,
    parameter int  depth     = 4
)
(
    input  logic     clk_in,
    input  logic     reset_in,
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty
);

    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam logic [ptr_width-1:0] last_ptr  = ptr_width'(depth - 1);
    localparam logic [ptr_width:0]   count_max = (ptr_width + 1)'(depth);

    payload_t             entries [depth];
    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width:0]   count;
    logic                 do_push;
    logic                 do_pop;

    assign full     = (count == count_max);
    assign empty    = (count == '0);
    assign do_push  = push & ~full;
    assign do_pop   = pop & ~empty;
    assign pop_data = empty ? payload_t'('0) : entries[rd_ptr];    // valid drops when empty

    always_ff @(posedge clk_in)
    begin
        if (do_push)
        begin
            entries[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push & ~do_pop)
            begin
                count <= count + 1'b1;
            end
            else if (do_pop & ~do_push)
            begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- source/cache_packet_generator.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_packet_generator
    import cache_packet_pkg::*, cache_test_pkg::*;
(
    input  logic            clk_in,
    input  logic            reset_in,
    input  logic            start,
    input  cache_addr_t     test_addr,
    input  cache_block_t    test_pattern,
    cache_port_if.generator way0,
    cache_port_if.generator way1,
    output logic            done,
    output logic            error,
    output cache_block_t    read_block
);

    localparam int timeout_width = $clog2(`CACHE_TIMEOUT_CYCLES + 1);
    localparam logic [timeout_width-1:0] timeout_limit = timeout_width'(`CACHE_TIMEOUT_CYCLES);

    way_state_t               state0;
    way_state_t               state1;
    logic [7:0]               req_count0;
    logic [7:0]               req_count1;
    logic [timeout_width-1:0] timeout0;
    logic [timeout_width-1:0] timeout1;
    cache_addr_t              addr_q;
    cache_block_t             pattern_q;
    logic [`CACHE_NUM_WAY-1:0] done_way;
    logic [`CACHE_NUM_WAY-1:0] error_way;
    logic                     return_seen;

    assign done_way    = {state1 == way_done, state0 == way_done};
    assign error_way   = {state1 == way_failed, state0 == way_failed};
    assign done        = &done_way;
    assign error       = |error_way;
    assign return_seen = way1.return_packet.valid & ~way1.return_ack;

    assign way0.return_ack = 1'b0;          // writes get no return

    always_ff @(posedge clk_in)
    begin
        if (start)
        begin
            addr_q    <= test_addr;
            pattern_q <= test_pattern;      // reference for the read check
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // way 0 issues the write

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            state0              <= way_idle;
            req_count0          <= '0;
            timeout0            <= '0;
            way0.request_packet <= '0;
        end
        else if (start)
        begin
            state0              <= way_issue;
            timeout0            <= '0;
            way0.request_packet <= '{cacheable: 1'b1, write: 1'b1, valid: 1'b1,
                                     port: cache_port_id_t'(0), byte_mask: '1,
                                     pkt_type: req_count0[`CACHE_PACKET_TYPE_WIDTH-1:0],
                                     data: test_pattern, addr: test_addr};
        end
        else if (state0 == way_issue)
        begin
            if (way0.request_ack)
            begin
                state0              <= way_done;
                req_count0          <= req_count0 + 1'b1;
                way0.request_packet <= '0;
            end
            else if (timeout0 == timeout_limit)
            begin
                state0              <= way_failed;
                way0.request_packet <= '0;
            end
            else
            begin
                timeout0 <= timeout0 + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // way 1 reads back once the write is through

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            state1              <= way_idle;
            req_count1          <= '0;
            timeout1            <= '0;
            read_block          <= '0;
            way1.request_packet <= '0;
        end
        else if (start)
        begin
            state1              <= way_idle;
            way1.request_packet <= '0;
        end
        else
        begin
            case (state1)
                way_idle:
                begin
                    if (state0 == way_done)
                    begin
                        state1              <= way_issue;
                        timeout1            <= '0;
                        way1.request_packet <= '{cacheable: 1'b1, write: 1'b0, valid: 1'b1,
                                                 port: cache_port_id_t'(1), byte_mask: '0,
                                                 pkt_type: req_count1[`CACHE_PACKET_TYPE_WIDTH-1:0],
                                                 data: '0, addr: addr_q};
                    end
                end
                way_issue:
                begin
                    if (way1.request_ack)
                    begin
                        state1              <= way_wait_return;
                        req_count1          <= req_count1 + 1'b1;
                        way1.request_packet <= '0;
                    end
                    else if (timeout1 == timeout_limit)
                    begin
                        state1              <= way_failed;
                        way1.request_packet <= '0;
                    end
                    else
                    begin
                        timeout1 <= timeout1 + 1'b1;
                    end
                end
                way_wait_return:
                begin
                    if (return_seen)
                    begin
                        if (way1.return_packet.data == pattern_q)
                        begin
                            state1     <= way_done;
                            read_block <= way1.return_packet.data;
                        end
                        else
                        begin
                            state1 <= way_failed;
                        end
                    end
                    else if (timeout1 == timeout_limit)
                    begin
                        state1 <= way_failed;
                    end
                    else
                    begin
                        timeout1 <= timeout1 + 1'b1;
                    end
                end
                default:
                begin
                    state1 <= state1;       // done and failed hold until start
                end
            endcase
        end
    end

    // ack one cycle after a return shows up, stale returns are drained too
    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            way1.return_ack <= 1'b0;
        end
        else
        begin
            way1.return_ack <= return_seen;
        end
    end

endmodule

//--- source/unified_cache_responder.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module unified_cache_responder
    import cache_packet_pkg::*;
(
    input  logic        clk_in,
    input  logic        reset_in,
    input  logic        stall,
    cache_port_if.cache port0,
    cache_port_if.cache port1
);

    localparam int offset_width = $clog2(`CACHE_BYTE_MASK_WIDTH);
    localparam int index_width  = $clog2(`CACHE_STORE_DEPTH);

    cache_block_t           store [`CACHE_STORE_DEPTH];
    logic                   grant0;
    logic                   grant1;
    logic                   req_push;
    logic                   req_full;
    logic                   req_pop;
    logic                   req_empty;
    cache_packet_t          req_in;
    cache_packet_t          req_head;
    logic                   ret_push;
    logic                   ret_full;
    logic                   ret_pop;
    logic                   ret_empty;
    cache_return_t          ret_in;
    cache_return_t          ret_head;
    logic [index_width-1:0] head_index;
    logic [index_width-1:0] wr_index;
    logic                   wr_pending;
    cache_block_t           wr_data;
    cache_block_t           read_data;

    ////////////////////////////////////////////////////////////////////////////
    // request side, way 0 wins a tie

    assign grant0   = ~stall & ~req_full & port0.request_packet.valid & ~port0.request_ack;
    assign grant1   = ~stall & ~req_full & port1.request_packet.valid & ~port1.request_ack
                    & ~grant0;
    assign req_push = grant0 | grant1;
    assign req_in   = grant0 ? port0.request_packet : port1.request_packet;

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            port0.request_ack <= 1'b0;
            port1.request_ack <= 1'b0;
            wr_pending        <= 1'b0;
        end
        else
        begin
            port0.request_ack <= grant0;
            port1.request_ack <= grant1;
            wr_pending        <= req_pop & req_head.write;
        end
    end

    packet_queue #(.payload_t(cache_packet_t), .depth(`CACHE_QUEUE_DEPTH)) request_queue
    (
        .clk_in    (clk_in),
        .reset_in  (reset_in),
        .push      (req_push),
        .push_data (req_in),
        .full      (req_full),
        .pop       (req_pop),
        .pop_data  (req_head),
        .empty     (req_empty)
    );

    ////////////////////////////////////////////////////////////////////////////
    // block store and return side

    assign head_index = req_head.addr[offset_width +: index_width];
    assign read_data  = (wr_pending && wr_index == head_index) ? wr_data : store[head_index];
    assign req_pop    = ~req_empty & (req_head.write | ~ret_full);   // reads wait for room
    assign ret_push   = req_pop & ~req_head.write;
    assign ret_in     = '{valid: 1'b1, port: req_head.port, data: read_data,
                          addr: req_head.addr};

    // full block write lands one cycle after the request leaves the queue
    always_ff @(posedge clk_in)
    begin
        if (req_pop & req_head.write)
        begin
            wr_index <= head_index;
            wr_data  <= req_head.data;
        end
        if (wr_pending)
        begin
            store[wr_index] <= wr_data;
        end
    end

    packet_queue #(.payload_t(cache_return_t), .depth(`CACHE_QUEUE_DEPTH)) return_queue
    (
        .clk_in    (clk_in),
        .reset_in  (reset_in),
        .push      (ret_push),
        .push_data (ret_in),
        .full      (ret_full),
        .pop       (ret_pop),
        .pop_data  (ret_head),
        .empty     (ret_empty)
    );

    assign ret_pop = ~ret_empty & ((ret_head.port == cache_port_id_t'(1)) ? port1.return_ack
                                                                          : port0.return_ack);
    assign port0.return_packet = (ret_head.port == cache_port_id_t'(0)) ? ret_head : '0;
    assign port1.return_packet = (ret_head.port == cache_port_id_t'(1)) ? ret_head : '0;

endmodule

//--- source/cache_test_top.sv
`timescale 1ns/1ps

module cache_test_top
    import cache_packet_pkg::*, cache_test_pkg::*;
(
    input  logic         clk_in,
    input  logic         reset_in,
    input  logic         start,
    input  cache_addr_t  test_addr,
    input  cache_block_t test_pattern,
    input  logic         stall,
    output logic         done,
    output logic         error,
    output cache_block_t read_block
);

    test_result_t result;

    cache_port_if way0_port ();             // write way
    cache_port_if way1_port ();             // read-back way

    cache_packet_generator generator
    (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .start        (start),
        .test_addr    (test_addr),
        .test_pattern (test_pattern),
        .way0         (way0_port.generator),
        .way1         (way1_port.generator),
        .done         (result.done),
        .error        (result.error),
        .read_block   (result.read_block)
    );

    unified_cache_responder responder
    (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .stall    (stall),
        .port0    (way0_port.cache),
        .port1    (way1_port.cache)
    );

    assign done       = result.done;
    assign error      = result.error;
    assign read_block = result.read_block;

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
#(
    parameter int half_period_ns = 10,
    parameter int reset_cycles   = 3
)
(
    output logic clk_in,
    output logic reset_in
);

    initial
    begin
        clk_in = 1'b0;
        forever #(half_period_ns) clk_in = ~clk_in;
    end

    initial
    begin
        reset_in = 1'b1;
        repeat (reset_cycles) @(posedge clk_in);
        #1;
        reset_in = 1'b0;                    // released just after the third edge
    end

endmodule

//--- dv/cache_test_sva.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_test_sva
    import cache_packet_pkg::*, cache_test_pkg::*;
(
    input logic         clk_in,
    input logic         reset_in,
    input logic         start,
    input logic         done,
    input logic         error,
    input cache_block_t read_block,
    input way_state_t   state0
);

    int violations = 0;

    error_sticky: assert property (@(posedge clk_in) disable iff (reset_in)
        $fell(error) |-> $past(start))
    else
    begin
        violations++;
        $error("error fell without a start");
    end

    clear_on_start: assert property (@(posedge clk_in) disable iff (reset_in)
        start |=> !done && !error)
    else
    begin
        violations++;
        $error("done or error still high in the cycle after start");
    end

    block_on_done: assert property (@(posedge clk_in) disable iff (reset_in)
        !$stable(read_block) |-> $rose(done))
    else
    begin
        violations++;
        $error("read_block changed without done rising");
    end

    // the write way leaves issue at the latest when its timeout runs out
    write_way_bounded: assert property (@(posedge clk_in) disable iff (reset_in)
        $rose(state0 == way_issue) |-> ##[1:`CACHE_TIMEOUT_CYCLES + 1] state0 != way_issue)
    else
    begin
        violations++;
        $error("write way stayed in issue past the timeout");
    end

endmodule

bind cache_test_top cache_test_sva assertions
(
    .clk_in     (clk_in),
    .reset_in   (reset_in),
    .start      (start),
    .done       (done),
    .error      (error),
    .read_block (read_block),
    .state0     (generator.state0)
);

//--- dv/cache_test_tb.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_test_tb
    import cache_packet_pkg::*, cache_test_pkg::*;
();

    localparam int num_rows       = 10;
    localparam int half_period_ns = 10;
    localparam int row_budget     = 2 * `CACHE_TIMEOUT_CYCLES + 20;
    localparam int error_hold     = 8;

    typedef struct
    {
        cache_addr_t  addr;
        cache_block_t pattern;
        int           stall_cycles;
        test_result_t expected;
    } test_row_t;

    logic         clk_in;
    logic         reset_in;
    logic         start;
    cache_addr_t  test_addr;
    cache_block_t test_pattern;
    logic         stall;
    logic         done;
    logic         error;
    cache_block_t read_block;
    test_row_t    rows [num_rows];
    int           row_count;
    cache_block_t last_good;
    integer       seed;

    tb_clock_gen #(.half_period_ns(half_period_ns), .reset_cycles(3)) clock_gen
    (
        .clk_in   (clk_in),
        .reset_in (reset_in)
    );

    cache_test_top uut
    (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .start        (start),
        .test_addr    (test_addr),
        .test_pattern (test_pattern),
        .stall        (stall),
        .done         (done),
        .error        (error),
        .read_block   (read_block)
    );

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            report_failure($sformatf("FAILED t=%0t %s is %b, expected %b",
                                     $time, what, actual, expected));
        end
    endtask

    task automatic check_block(input string what, input cache_block_t expected,
                               input cache_block_t actual);
        if (actual !== expected)
        begin
            report_failure($sformatf("FAILED t=%0t %s is %h, expected %h",
                                     $time, what, actual, expected));
        end
    endtask

    task automatic check_result(input string what, input test_result_t expected,
                                input test_result_t actual);
        if (actual !== expected)
        begin
            report_failure($sformatf("FAILED t=%0t %s done %b error %b block %h, expected %b %b %h",
                                     $time, what, actual.done, actual.error, actual.read_block,
                                     expected.done, expected.error, expected.read_block));
        end
    endtask

    // a stall past the timeout fails the write way, read_block keeps the last good block
    task automatic add_row(input cache_addr_t addr, input cache_block_t pattern,
                           input int stall_cycles);
        test_row_t row;
        row.addr         = addr;
        row.pattern      = pattern;
        row.stall_cycles = stall_cycles;
        if (stall_cycles > `CACHE_TIMEOUT_CYCLES)
        begin
            row.expected = '{done: 1'b0, error: 1'b1, read_block: last_good};
        end
        else
        begin
            row.expected = '{done: 1'b1, error: 1'b0, read_block: pattern};
            last_good    = pattern;
        end
        rows[row_count] = row;
        row_count++;
    endtask

    task automatic build_table();
        int i;
        row_count = 0;
        last_good = '0;
        add_row(32'h0000_0100, 64'h0123_4567_89ab_cdef, 0);
        add_row(32'h0000_0100, 64'hfedc_ba98_7654_3210, 0);    // overwrite the same block
        add_row(32'h0000_0100, 64'h5a5a_a5a5_0f0f_f0f0, 0);
        for (i = 0; i < `CACHE_STORE_DEPTH; i++)
        begin
            add_row(cache_addr_t'(32'h0000_2000 + (i << 3)), {$random(seed), $random(seed)}, 0);
        end
        add_row(32'h0000_0018, 64'h1357_9bdf_2468_ace0, `CACHE_TIMEOUT_CYCLES / 4);
        add_row(32'h0000_0018, 64'h7e7e_1818_c3c3_3c3c, `CACHE_TIMEOUT_CYCLES + 16);
        add_row(32'h0000_0018, 64'h0f1e_2d3c_4b5a_6978, 0);     // recovers after the error
    endtask

    task automatic run_row(input int index);
        test_row_t    row;
        test_result_t actual;
        int           cycle;
        int           waited;
        row = rows[index];
        @(posedge clk_in);
        #1;
        start        = 1'b1;
        test_addr    = row.addr;
        test_pattern = row.pattern;
        stall        = (row.stall_cycles > 0);
        @(posedge clk_in);
        #1;
        start = 1'b0;
        check_flag("done after start", 1'b0, done);
        check_flag("error after start", 1'b0, error);
        for (cycle = 1; cycle < row.stall_cycles; cycle++)
        begin
            @(posedge clk_in);
            #1;
        end
        stall  = 1'b0;
        waited = 0;
        while (!done && !error && waited < row_budget)
        begin
            @(posedge clk_in);
            #1;
            waited++;
        end
        if (!done && !error)
        begin
            report_failure($sformatf("row %0d gave neither done nor error within %0d cycles",
                                     index, row_budget));
        end
        else
        begin
            actual = '{done: done, error: error, read_block: read_block};
            check_result($sformatf("row %0d", index), row.expected, actual);
            for (cycle = 0; row.expected.error && cycle < error_hold; cycle++)
            begin
                @(posedge clk_in);
                #1;
                check_flag("sticky error", 1'b1, error);
                check_flag("done during error", 1'b0, done);
                check_block("held read_block", row.expected.read_block, read_block);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence

    initial
    begin : main
        int index;
        start        = 1'b0;
        test_addr    = '0;
        test_pattern = '0;
        stall        = 1'b0;
        seed         = 32'h45c6c872;
        build_table();
        wait (reset_in === 1'b0);
        repeat (5)
        begin
            @(posedge clk_in);
            #1;
            check_flag("done before first start", 1'b0, done);
            check_flag("error before first start", 1'b0, error);
        end
        for (index = 0; index < num_rows; index++)
        begin
            run_row(index);
        end
        if (uut.assertions.violations == 0)
        begin
            $display("=== PASS ===");
            $finish;
        end
        else
        begin
            report_failure("bound assertions failed during the run");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // bound assertions

    initial
    begin : assertion_monitor
        wait (uut.assertions.violations != 0);
        report_failure("a bound assertion failed");
    end

    ////////////////////////////////////////////////////////////////////////////
    // watchdog

    initial
    begin : watchdog
        #((num_rows * row_budget + 20) * 2 * half_period_ns);
        report_failure("watchdog expired before all rows finished");
    end

endmodule

//--- list.f
+incdir+source
source/cache_packet_pkg.sv
source/cache_test_pkg.sv
source/cache_port_if.sv
source/packet_queue.sv
source/cache_packet_generator.sv
source/unified_cache_responder.sv
source/cache_test_top.sv
dv/tb_clock_gen.sv
dv/cache_test_sva.sv
dv/cache_test_tb.sv
